/* design/bus_map_pkg.sv */
package bus_map_pkg;

    // masters
    localparam int NUM_MASTERS = 3;
    localparam int MIDX_BITS   = 2;

    // slaves, one extra index for the default slave
    localparam int NUM_SLAVES = 8;
    localparam int SIDX_BITS  = 4;

    // slave indices
    localparam logic [SIDX_BITS-1:0] S_ROM     = 4'd0;
    localparam logic [SIDX_BITS-1:0] S_IM      = 4'd1;
    localparam logic [SIDX_BITS-1:0] S_DM      = 4'd2;
    localparam logic [SIDX_BITS-1:0] S_SCTRL   = 4'd3;
    localparam logic [SIDX_BITS-1:0] S_WDT     = 4'd4;
    localparam logic [SIDX_BITS-1:0] S_DRAM    = 4'd5;
    localparam logic [SIDX_BITS-1:0] S_EPU     = 4'd6;
    localparam logic [SIDX_BITS-1:0] S_DMA     = 4'd7;
    localparam logic [SIDX_BITS-1:0] S_DEFAULT = 4'd8;

    // region bases, upper halfword of the address
    localparam logic [15:0] ROM_HI   = 16'h0000;
    localparam logic [15:0] IM_HI    = 16'h0001;
    localparam logic [15:0] DM_HI    = 16'h0002;
    localparam logic [15:0] DMA_HI   = 16'h0003;
    localparam logic [15:0] EPU_HI   = 16'h0010;
    localparam logic [15:0] SCTRL_HI = 16'h1000;
    localparam logic [15:0] WDT_HI   = 16'h1001;
    // dram is matched on the top byte only
    localparam logic [7:0]  DRAM_TOP = 8'h20;

    // current bus owner and its target
    typedef struct packed {
        logic                 busy;
        logic [MIDX_BITS-1:0] master;
        logic [SIDX_BITS-1:0] slave;
    } grant_t;

endpackage

/* design/axi_pkg.sv */
package axi_pkg;

    // slave side id width depends on the master index width
    import bus_map_pkg::*;

    // bus widths
    localparam int ADDR_BITS  = 32;
    localparam int DATA_BITS  = 32;
    localparam int STRB_BITS  = DATA_BITS / 8;
    localparam int LEN_BITS   = 8;
    localparam int SIZE_BITS  = 3;
    localparam int BURST_BITS = 2;
    localparam int RESP_BITS  = 2;

    // id as issued by a master
    localparam int MID_BITS = 4;
    // master index sits above the master id on the slave side
    localparam int SID_BITS = MID_BITS + MIDX_BITS;

    // response codes
    localparam logic [RESP_BITS-1:0] RESP_OKAY   = 2'b00;
    localparam logic [RESP_BITS-1:0] RESP_DECERR = 2'b11;

    // write address, master side
    typedef struct packed {
        logic [MID_BITS-1:0]   id;
        logic [ADDR_BITS-1:0]  addr;
        logic [LEN_BITS-1:0]   len;
        logic [SIZE_BITS-1:0]  size;
        logic [BURST_BITS-1:0] burst;
    } aw_m_t;

    // write address, slave side with widened id
    typedef struct packed {
        logic [SID_BITS-1:0]   id;
        logic [ADDR_BITS-1:0]  addr;
        logic [LEN_BITS-1:0]   len;
        logic [SIZE_BITS-1:0]  size;
        logic [BURST_BITS-1:0] burst;
    } aw_s_t;

    // one write beat
    // last stays the lsb, the channel router reads it from there
    typedef struct packed {
        logic [DATA_BITS-1:0] data;
        logic [STRB_BITS-1:0] strb;
        logic                 last;
    } w_t;

    // write response, master side
    typedef struct packed {
        logic [MID_BITS-1:0]  id;
        logic [RESP_BITS-1:0] resp;
    } b_m_t;

    // write response, slave side
    typedef struct packed {
        logic [SID_BITS-1:0]  id;
        logic [RESP_BITS-1:0] resp;
    } b_s_t;

endpackage

/* design/write_addr_decoder.sv */
`timescale 1ns/1ps

module write_addr_decoder
    import axi_pkg::*;
    import bus_map_pkg::*;
(
    input  logic [ADDR_BITS-1:0] addr,
    output logic [SIDX_BITS-1:0] slave
);

    logic [15:0] addr_hi;
    logic [7:0]  addr_top;

    // region fields of the address
    assign addr_hi  = addr[ADDR_BITS-1 -: 16];
    assign addr_top = addr[ADDR_BITS-1 -: 8];

    always_comb begin
        // dram covers the whole 0x20 top byte
        if (addr_top == DRAM_TOP) begin
            slave = S_DRAM;
        end else begin
            case (addr_hi)
                ROM_HI:   slave = S_ROM;
                IM_HI:    slave = S_IM;
                DM_HI:    slave = S_DM;
                DMA_HI:   slave = S_DMA;
                EPU_HI:   slave = S_EPU;
                SCTRL_HI: slave = S_SCTRL;
                WDT_HI:   slave = S_WDT;
                // hole in the map
                default:  slave = S_DEFAULT;
            endcase
        end
    end

endmodule

/* design/write_arbiter.sv */
`timescale 1ns/1ps

module write_arbiter
    import bus_map_pkg::*;
(
    input  logic                   ACLK,
    input  logic                   ARESETn,
    input  logic [NUM_MASTERS-1:0] awvalid,
    input  logic [SIDX_BITS-1:0]   target [NUM_MASTERS],
    input  logic                   w_last_done,
    output grant_t                 grant
);

    typedef enum logic {
        IDLE,
        OWNED
    } state_t;

    state_t               state;
    logic                 win_valid;
    logic [MIDX_BITS-1:0] win_master;
    logic [SIDX_BITS-1:0] win_target;
    logic [MIDX_BITS-1:0] own_master;
    logic [SIDX_BITS-1:0] own_slave;

    // fixed priority pick
    // order is M0 first, then M2, then M1
    always_comb begin
        win_valid  = |awvalid;
        win_master = '0;
        win_target = S_DEFAULT;
        if (awvalid[0]) begin
            win_master = MIDX_BITS'(0);
            win_target = target[0];
        end else if (awvalid[2]) begin
            win_master = MIDX_BITS'(2);
            win_target = target[2];
        end else if (awvalid[1]) begin
            win_master = MIDX_BITS'(1);
            win_target = target[1];
        end
    end

    // grant register
    always_ff @(posedge ACLK) begin
        if (!ARESETn) begin
            state      <= IDLE;
            own_master <= '0;
            own_slave  <= S_DEFAULT;
        end else begin
            case (state)
                IDLE: begin
                    // latch the winner with its decoded slave
                    if (win_valid) begin
                        state      <= OWNED;
                        own_master <= win_master;
                        own_slave  <= win_target;
                    end
                end
                OWNED: begin
                    // release on the accepted last beat
                    // new requests wait one idle cycle
                    if (w_last_done) begin
                        state <= IDLE;
                    end
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    // routers see busy only while owned
    assign grant = '{
        busy:   (state == OWNED),
        master: own_master,
        slave:  own_slave
    };

endmodule

/* design/write_channel_router.sv */
`timescale 1ns/1ps

module write_channel_router
    import bus_map_pkg::*;
#(
    parameter type payload_t = logic,
    parameter bit  HAS_LAST  = 1'b0
)(
    input  grant_t                 grant,
    // master side
    input  logic [NUM_MASTERS-1:0] m_valid,
    output logic [NUM_MASTERS-1:0] m_ready,
    input  payload_t               m_data [NUM_MASTERS],
    // slave side, top entry is the default slave
    output logic [NUM_SLAVES:0]    s_valid,
    input  logic [NUM_SLAVES:0]    s_ready,
    output payload_t               s_data [NUM_SLAVES+1],
    output logic                   fire_last
);

    logic                        own_valid;
    payload_t                    own_data;
    logic                        sel_ready;
    logic [$bits(payload_t)-1:0] own_bits;

    // owner's valid and payload
    always_comb begin
        own_valid = 1'b0;
        own_data  = '0;
        for (int m = 0; m < NUM_MASTERS; m++) begin
            if (grant.master == MIDX_BITS'(m)) begin
                own_valid = m_valid[m];
                own_data  = m_data[m];
            end
        end
    end

    // ready of the granted slave
    always_comb begin
        sel_ready = 1'b0;
        for (int s = 0; s <= NUM_SLAVES; s++) begin
            if (grant.slave == SIDX_BITS'(s)) begin
                sel_ready = s_ready[s];
            end
        end
    end

    // demux forward, mux ready back
    // nothing passes without busy
    always_comb begin
        for (int m = 0; m < NUM_MASTERS; m++) begin
            m_ready[m] = grant.busy && (grant.master == MIDX_BITS'(m)) && sel_ready;
        end
        for (int s = 0; s <= NUM_SLAVES; s++) begin
            s_valid[s] = grant.busy && (grant.slave == SIDX_BITS'(s)) && own_valid;
            // payload shared, valid picks the slave
            s_data[s]  = own_data;
        end
    end

    // last flag is the payload lsb when present
    assign own_bits  = own_data;
    assign fire_last = HAS_LAST && grant.busy && own_valid && sel_ready && own_bits[0];

endmodule

/* design/write_resp_router.sv */
`timescale 1ns/1ps

module write_resp_router
    import axi_pkg::*;
    import bus_map_pkg::*;
(
    // slave side, top entry is the default slave
    input  logic [NUM_SLAVES:0]    s_bvalid,
    input  b_s_t                   s_b [NUM_SLAVES+1],
    output logic [NUM_SLAVES:0]    s_bready,
    // master side
    output logic [NUM_MASTERS-1:0] m_bvalid,
    output b_m_t                   m_b [NUM_MASTERS],
    input  logic [NUM_MASTERS-1:0] m_bready
);

    logic [MIDX_BITS-1:0] dest [NUM_SLAVES+1];
    logic [SIDX_BITS-1:0] pick [NUM_MASTERS];

    // master index from the upper id bits
    always_comb begin
        for (int s = 0; s <= NUM_SLAVES; s++) begin
            dest[s] = s_b[s].id[SID_BITS-1 -: MIDX_BITS];
        end
    end

    // one selector per master
    // lowest slave index wins, so a stalled master holds only its own source
    always_comb begin
        for (int m = 0; m < NUM_MASTERS; m++) begin
            m_bvalid[m] = 1'b0;
            pick[m]     = '0;
            // scan downward, last hit is the lowest index
            for (int s = NUM_SLAVES; s >= 0; s--) begin
                if (s_bvalid[s] && (dest[s] == MIDX_BITS'(m))) begin
                    m_bvalid[m] = 1'b1;
                    pick[m]     = SIDX_BITS'(s);
                end
            end
            // strip the master index
            m_b[m] = '{id: s_b[pick[m]].id[MID_BITS-1:0], resp: s_b[pick[m]].resp};
        end
    end

    // ready back to the picked slave only
    always_comb begin
        for (int s = 0; s <= NUM_SLAVES; s++) begin
            s_bready[s] = 1'b0;
            for (int m = 0; m < NUM_MASTERS; m++) begin
                if (m_bvalid[m] && (pick[m] == SIDX_BITS'(s))) begin
                    s_bready[s] = m_bready[m];
                end
            end
        end
    end

endmodule

/* design/write_default_slave.sv */
`timescale 1ns/1ps

module write_default_slave
    import axi_pkg::*;
(
    input  logic  ACLK,
    input  logic  ARESETn,
    // address
    input  logic  awvalid,
    output logic  awready,
    input  aw_s_t aw,
    // data
    input  logic  wvalid,
    output logic  wready,
    input  w_t    w,
    // response
    output logic  bvalid,
    input  logic  bready,
    output b_s_t  b
);

    typedef enum logic [1:0] {
        ADDR,
        DRAIN,
        RESP
    } state_t;

    state_t              state;
    logic [SID_BITS-1:0] id_q;

    // one handshake per state
    assign awready = (state == ADDR);
    assign wready  = (state == DRAIN);
    assign bvalid  = (state == RESP);
    assign b       = '{id: id_q, resp: RESP_DECERR};

    always_ff @(posedge ACLK) begin
        if (!ARESETn) begin
            state <= ADDR;
        end else begin
            case (state)
                ADDR: begin
                    if (awvalid) begin
                        state <= DRAIN;
                    end
                end
                DRAIN: begin
                    // beats are dropped until last
                    if (wvalid && w.last) begin
                        state <= RESP;
                    end
                end
                RESP: begin
                    // no new address until the error is taken
                    if (bready) begin
                        state <= ADDR;
                    end
                end
                default: begin
                    state <= ADDR;
                end
            endcase
        end
    end

    // id echoed in the response
    always_ff @(posedge ACLK) begin
        if ((state == ADDR) && awvalid) begin
            id_q <= aw.id;
        end
    end

endmodule

/* design/write_interconnect.sv */
`timescale 1ns/1ps

module write_interconnect
    import axi_pkg::*;
    import bus_map_pkg::*;
(
    input  logic                   ACLK,
    input  logic                   ARESETn,
    // masters
    input  logic [NUM_MASTERS-1:0] m_awvalid,
    output logic [NUM_MASTERS-1:0] m_awready,
    input  aw_m_t                  m_aw [NUM_MASTERS],
    input  logic [NUM_MASTERS-1:0] m_wvalid,
    output logic [NUM_MASTERS-1:0] m_wready,
    input  w_t                     m_w [NUM_MASTERS],
    output logic [NUM_MASTERS-1:0] m_bvalid,
    input  logic [NUM_MASTERS-1:0] m_bready,
    output b_m_t                   m_b [NUM_MASTERS],
    // slaves
    output logic [NUM_SLAVES-1:0]  s_awvalid,
    input  logic [NUM_SLAVES-1:0]  s_awready,
    output aw_s_t                  s_aw [NUM_SLAVES],
    output logic [NUM_SLAVES-1:0]  s_wvalid,
    input  logic [NUM_SLAVES-1:0]  s_wready,
    output w_t                     s_w [NUM_SLAVES],
    input  logic [NUM_SLAVES-1:0]  s_bvalid,
    output logic [NUM_SLAVES-1:0]  s_bready,
    input  b_s_t                   s_b [NUM_SLAVES]
);

    logic [SIDX_BITS-1:0] target [NUM_MASTERS];
    aw_s_t                aw_wide [NUM_MASTERS];
    grant_t               grant;
    logic                 w_last_done;

    // slave side incl. default slave at index NUM_SLAVES
    logic [NUM_SLAVES:0]  awvalid_all;
    logic [NUM_SLAVES:0]  awready_all;
    aw_s_t                aw_all [NUM_SLAVES+1];
    logic [NUM_SLAVES:0]  wvalid_all;
    logic [NUM_SLAVES:0]  wready_all;
    w_t                   w_all [NUM_SLAVES+1];
    logic [NUM_SLAVES:0]  bvalid_all;
    logic [NUM_SLAVES:0]  bready_all;
    b_s_t                 b_all [NUM_SLAVES+1];

    for (genvar m = 0; m < NUM_MASTERS; m++) begin : g_master
        // each request carries its own target
        write_addr_decoder u_dec (
            .addr  (m_aw[m].addr),
            .slave (target[m])
        );
        // master index prepended, lands in the upper id bits
        assign aw_wide[m] = {MIDX_BITS'(m), m_aw[m]};
    end

    // real slaves
    assign s_awvalid                    = awvalid_all[NUM_SLAVES-1:0];
    assign awready_all[NUM_SLAVES-1:0] = s_awready;
    assign s_wvalid                     = wvalid_all[NUM_SLAVES-1:0];
    assign wready_all[NUM_SLAVES-1:0]  = s_wready;
    assign bvalid_all[NUM_SLAVES-1:0]  = s_bvalid;
    assign s_bready                     = bready_all[NUM_SLAVES-1:0];

    for (genvar s = 0; s < NUM_SLAVES; s++) begin : g_slave
        assign s_aw[s]  = aw_all[s];
        assign s_w[s]   = w_all[s];
        assign b_all[s] = s_b[s];
    end

    write_arbiter u_arb (
        .ACLK        (ACLK),
        .ARESETn     (ARESETn),
        .awvalid     (m_awvalid),
        .target      (target),
        .w_last_done (w_last_done),
        .grant       (grant)
    );

    // address channel, no last flag
    write_channel_router #(
        .payload_t (aw_s_t),
        .HAS_LAST  (1'b0)
    ) u_aw_router (
        .grant     (grant),
        .m_valid   (m_awvalid),
        .m_ready   (m_awready),
        .m_data    (aw_wide),
        .s_valid   (awvalid_all),
        .s_ready   (awready_all),
        .s_data    (aw_all),
        .fire_last ()
    );

    // data channel, last beat releases the bus
    write_channel_router #(
        .payload_t (w_t),
        .HAS_LAST  (1'b1)
    ) u_w_router (
        .grant     (grant),
        .m_valid   (m_wvalid),
        .m_ready   (m_wready),
        .m_data    (m_w),
        .s_valid   (wvalid_all),
        .s_ready   (wready_all),
        .s_data    (w_all),
        .fire_last (w_last_done)
    );

    write_resp_router u_resp_router (
        .s_bvalid (bvalid_all),
        .s_b      (b_all),
        .s_bready (bready_all),
        .m_bvalid (m_bvalid),
        .m_b      (m_b),
        .m_bready (m_bready)
    );

    // catches unmapped writes
    write_default_slave u_default_slave (
        .ACLK    (ACLK),
        .ARESETn (ARESETn),
        .awvalid (awvalid_all[NUM_SLAVES]),
        .awready (awready_all[NUM_SLAVES]),
        .aw      (aw_all[NUM_SLAVES]),
        .wvalid  (wvalid_all[NUM_SLAVES]),
        .wready  (wready_all[NUM_SLAVES]),
        .w       (w_all[NUM_SLAVES]),
        .bvalid  (bvalid_all[NUM_SLAVES]),
        .bready  (bready_all[NUM_SLAVES]),
        .b       (b_all[NUM_SLAVES])
    );

endmodule

/* testbench/tb_write_interconnect.sv */
`timescale 1ns/1ps

module tb_write_interconnect
    import axi_pkg::*;
    import bus_map_pkg::*;
();

    // cycles before a wait gives up
    localparam int WAIT_LIMIT = 400;
    localparam int CH_AW = 0;
    localparam int CH_W  = 1;
    localparam int CH_B  = 2;

    logic ACLK = 1'b0;
    logic ARESETn;

    // master side
    logic [NUM_MASTERS-1:0] m_awvalid;
    logic [NUM_MASTERS-1:0] m_awready;
    aw_m_t                  m_aw [NUM_MASTERS];
    logic [NUM_MASTERS-1:0] m_wvalid;
    logic [NUM_MASTERS-1:0] m_wready;
    w_t                     m_w [NUM_MASTERS];
    logic [NUM_MASTERS-1:0] m_bvalid;
    logic [NUM_MASTERS-1:0] m_bready;
    b_m_t                   m_b [NUM_MASTERS];

    // slave side
    logic [NUM_SLAVES-1:0]  s_awvalid;
    logic [NUM_SLAVES-1:0]  s_awready;
    aw_s_t                  s_aw [NUM_SLAVES];
    logic [NUM_SLAVES-1:0]  s_wvalid;
    logic [NUM_SLAVES-1:0]  s_wready;
    w_t                     s_w [NUM_SLAVES];
    logic [NUM_SLAVES-1:0]  s_bvalid;
    logic [NUM_SLAVES-1:0]  s_bready;
    b_s_t                   s_b [NUM_SLAVES];

    // slave model state
    aw_s_t                  aw_log [NUM_SLAVES][$];
    w_t                     w_log [NUM_SLAVES][$];
    logic [SID_BITS-1:0]    b_pend [NUM_SLAVES][$];
    logic [SID_BITS-1:0]    cur_id [NUM_SLAVES];
    logic [NUM_SLAVES-1:0]  b_taken;
    int                     arrivals [$];

    // last response seen per master
    b_m_t                   last_b [NUM_MASTERS];
    logic                   burst_open;

    int                     errors;
    int                     tests_run;
    int                     tests_failed;
    int                     errors_at_start;
    string                  test_name;
    logic [31:0]            rng = 32'hba9c_f5db;

    // one base per slave in slave index order
    logic [31:0] region_base [NUM_SLAVES] = '{
        32'h0000_0000, 32'h0001_0000, 32'h0002_0000, 32'h1000_0000,
        32'h1001_0000, 32'h2000_0000, 32'h0010_0000, 32'h0003_0000
    };

    always begin
        #5;
        ACLK = ~ACLK;
    end

    write_interconnect DUT (
        .ACLK      (ACLK),
        .ARESETn   (ARESETn),
        .m_awvalid (m_awvalid),
        .m_awready (m_awready),
        .m_aw      (m_aw),
        .m_wvalid  (m_wvalid),
        .m_wready  (m_wready),
        .m_w       (m_w),
        .m_bvalid  (m_bvalid),
        .m_bready  (m_bready),
        .m_b       (m_b),
        .s_awvalid (s_awvalid),
        .s_awready (s_awready),
        .s_aw      (s_aw),
        .s_wvalid  (s_wvalid),
        .s_wready  (s_wready),
        .s_w       (s_w),
        .s_bvalid  (s_bvalid),
        .s_bready  (s_bready),
        .s_b       (s_b)
    );

    // lcg with numerical recipes constants
    function automatic logic [31:0] lcg_next();
        rng = rng * 32'd1664525 + 32'd1013904223;
        return rng;
    endfunction

    // address map by ranges
    // 8 means unmapped
    function automatic int expected_slave(input logic [31:0] a);
        if (a[31:24] == 8'h20) return 5;
        if (a < 32'h0001_0000) return 0;
        if (a < 32'h0002_0000) return 1;
        if (a < 32'h0003_0000) return 2;
        if (a < 32'h0004_0000) return 7;
        if (a >= 32'h0010_0000 && a < 32'h0011_0000) return 6;
        if (a >= 32'h1000_0000 && a < 32'h1001_0000) return 3;
        if (a >= 32'h1001_0000 && a < 32'h1002_0000) return 4;
        return 8;
    endfunction

    task automatic report_mismatch(input string msg);
        $display("MISMATCH at %0t: %s", $time, msg);
        errors++;
    endtask

    task automatic finish_run();
        $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    endtask

    // concurrent checks idle during reset
    assert property (@(posedge ACLK) disable iff (!ARESETn) $onehot0(s_awvalid))
        else report_mismatch("awvalid raised at more than one slave");
    assert property (@(posedge ACLK) disable iff (!ARESETn) $onehot0(s_wvalid))
        else report_mismatch("wvalid raised at more than one slave");
    // one owner sees ready at a time
    assert property (@(posedge ACLK) disable iff (!ARESETn) $onehot0(m_awready | m_wready))
        else report_mismatch("ready given to more than one master");
    // no new address before the last beat
    assert property (@(posedge ACLK) disable iff (!ARESETn)
                     !(burst_open && |(m_awvalid & m_awready)))
        else report_mismatch("address accepted while a burst was open");

    // open from aw handshake to last w beat
    always @(posedge ACLK) begin
        if (!ARESETn) begin
            burst_open <= 1'b0;
        end else begin
            if (|(m_awvalid & m_awready)) begin
                burst_open <= 1'b1;
            end
            for (int m = 0; m < NUM_MASTERS; m++) begin
                if (m_wvalid[m] && m_wready[m] && m_w[m].last) begin
                    burst_open <= 1'b0;
                end
            end
        end
    end

    // log what each slave accepts
    task automatic observe_slaves();
        for (int s = 0; s < NUM_SLAVES; s++) begin
            if (ARESETn && s_awvalid[s] && s_awready[s]) begin
                aw_log[s].push_back(s_aw[s]);
                cur_id[s] = s_aw[s].id;
                arrivals.push_back(int'(s_aw[s].id[SID_BITS-1 -: MIDX_BITS]));
            end
            if (ARESETn && s_wvalid[s] && s_wready[s]) begin
                w_log[s].push_back(s_w[s]);
                // response queued once the burst ends
                if (s_w[s].last) begin
                    b_pend[s].push_back(cur_id[s]);
                end
            end
            b_taken[s] = ARESETn && s_bvalid[s] && s_bready[s];
        end
    endtask

    // random stalls and okay responses
    task automatic drive_slaves();
        logic [31:0] r;
        for (int s = 0; s < NUM_SLAVES; s++) begin
            r = lcg_next();
            if (!ARESETn) begin
                s_awready[s] = 1'b0;
                s_wready[s]  = 1'b0;
                s_bvalid[s]  = 1'b0;
                b_pend[s].delete();
            end else begin
                // roughly one stall in four
                s_awready[s] = (r[21:20] != 2'b00);
                s_wready[s]  = (r[25:24] != 2'b00);
                if (b_taken[s]) begin
                    s_bvalid[s] = 1'b0;
                end
                if (!s_bvalid[s] && b_pend[s].size() > 0) begin
                    s_b[s]      = '{id: b_pend[s].pop_front(), resp: RESP_OKAY};
                    s_bvalid[s] = 1'b1;
                end
            end
        end
    endtask

    // sample at negedge
    // drive 1 ns after posedge
    initial begin : slave_models
        s_awready = '0;
        s_wready  = '0;
        s_bvalid  = '0;
        b_taken   = '0;
        for (int s = 0; s < NUM_SLAVES; s++) begin
            s_b[s]    = '0;
            cur_id[s] = '0;
        end
        forever begin
            @(negedge ACLK);
            observe_slaves();
            @(posedge ACLK);
            #1;
            drive_slaves();
        end
    end

    // wait for ready or bvalid on one master channel
    task automatic wait_handshake(input int m, input int chan);
        logic seen;
        seen = 1'b0;
        for (int t = 0; t < WAIT_LIMIT && !seen; t++) begin
            @(negedge ACLK);
            case (chan)
                CH_AW:   seen = m_awready[m];
                CH_W:    seen = m_wready[m];
                default: seen = m_bvalid[m];
            endcase
        end
        if (!seen) begin
            $display("timeout: master %0d waited %0d cycles on channel %0d",
                     m, WAIT_LIMIT, chan);
            errors++;
            finish_run();
        end else begin
            last_b[m] = m_b[m];
            @(posedge ACLK);
            #1;
        end
    endtask

    // one burst then a compare against the mapped slave's log
    task automatic issue_write(input int m, input logic [ADDR_BITS-1:0] addr,
                               input logic [MID_BITS-1:0] id, input int len);
        logic [DATA_BITS-1:0] beats [$];
        aw_s_t                got_aw;
        w_t                   got_w;
        int                   s;
        s = expected_slave(addr);
        for (int i = 0; i <= len; i++) begin
            beats.push_back(lcg_next());
        end
        m_aw[m]      = '{id: id, addr: addr, len: 8'(len), size: 3'd2, burst: 2'b01};
        m_awvalid[m] = 1'b1;
        wait_handshake(m, CH_AW);
        m_awvalid[m] = 1'b0;
        for (int i = 0; i <= len; i++) begin
            m_w[m]      = '{data: beats[i], strb: '1, last: (i == len)};
            m_wvalid[m] = 1'b1;
            wait_handshake(m, CH_W);
        end
        m_wvalid[m] = 1'b0;
        // unmapped writes leave every log empty
        if (s < NUM_SLAVES) begin
            assert (aw_log[s].size() == 1)
                else report_mismatch($sformatf("slave %0d got %0d addresses, expected 1",
                                               s, aw_log[s].size()));
            if (aw_log[s].size() > 0) begin
                got_aw = aw_log[s].pop_front();
                assert (got_aw.addr == addr && got_aw.id == {MIDX_BITS'(m), id}
                        && got_aw.len == 8'(len) && got_aw.size == 3'd2
                        && got_aw.burst == 2'b01)
                    else report_mismatch($sformatf("slave %0d addr %h id %h, expected %h %h",
                                                   s, got_aw.addr, got_aw.id, addr,
                                                   {MIDX_BITS'(m), id}));
            end
            assert (w_log[s].size() == len + 1)
                else report_mismatch($sformatf("slave %0d got %0d beats, expected %0d",
                                               s, w_log[s].size(), len + 1));
            for (int i = 0; i <= len && w_log[s].size() > 0; i++) begin
                got_w = w_log[s].pop_front();
                assert (got_w.data == beats[i] && got_w.strb == '1
                        && got_w.last == (i == len))
                    else report_mismatch($sformatf("slave %0d beat %0d data %h last %b",
                                                   s, i, got_w.data, got_w.last));
            end
        end
    endtask

    task automatic take_resp(input int m, input logic [MID_BITS-1:0] id,
                             input logic [RESP_BITS-1:0] resp);
        m_bready[m] = 1'b1;
        wait_handshake(m, CH_B);
        m_bready[m] = 1'b0;
        assert (last_b[m].id == id && last_b[m].resp == resp)
            else report_mismatch($sformatf("master %0d response id %h resp %b, expected %h %b",
                                           m, last_b[m].id, last_b[m].resp, id, resp));
    endtask

    task automatic write_and_check(input int m, input logic [ADDR_BITS-1:0] addr,
                                   input logic [MID_BITS-1:0] id, input int len);
        issue_write(m, addr, id, len);
        take_resp(m, id, (expected_slave(addr) == 8) ? RESP_DECERR : RESP_OKAY);
    endtask

    task automatic check_idle_outputs(input string when);
        assert (s_awvalid == '0 && s_wvalid == '0 && m_bvalid == '0
                && m_awready == '0 && m_wready == '0)
            else report_mismatch($sformatf("valid or ready high %s", when));
    endtask

    // leftovers mean a write landed at the wrong slave
    task automatic check_logs_empty();
        for (int s = 0; s < NUM_SLAVES; s++) begin
            assert (aw_log[s].size() == 0 && w_log[s].size() == 0)
                else report_mismatch($sformatf("slave %0d holds %0d stray addresses, %0d beats",
                                               s, aw_log[s].size(), w_log[s].size()));
            aw_log[s].delete();
            w_log[s].delete();
        end
    endtask

    task automatic begin_test(input string name);
        test_name       = name;
        errors_at_start = errors;
    endtask

    task automatic end_test();
        check_logs_empty();
        tests_run++;
        if (errors == errors_at_start) begin
            $display("test %0d %s: pass", tests_run, test_name);
        end else begin
            tests_failed++;
            $display("test %0d %s: FAIL, %0d errors", tests_run, test_name,
                     errors - errors_at_start);
        end
    endtask

    initial begin : main
        logic [31:0] addr;
        ARESETn      = 1'b0;
        m_awvalid    = '0;
        m_wvalid     = '0;
        m_bready     = '0;
        errors       = 0;
        tests_run    = 0;
        tests_failed = 0;
        for (int m = 0; m < NUM_MASTERS; m++) begin
            m_aw[m] = '0;
            m_w[m]  = '0;
        end

        // reset held for two edges
        begin_test("reset state");
        @(posedge ACLK);
        #1;
        check_idle_outputs("during reset");
        @(posedge ACLK);
        #1;
        check_idle_outputs("in the last reset cycle");
        ARESETn = 1'b1;
        @(posedge ACLK);
        #1;
        check_idle_outputs("after reset");
        end_test();

        // every master into every region
        begin_test("address routing");
        for (int m = 0; m < NUM_MASTERS; m++) begin
            for (int s = 0; s < NUM_SLAVES; s++) begin
                addr = region_base[s] | (lcg_next() & ((s == 5) ? 32'h00ff_fffc
                                                                : 32'h0000_fffc));
                write_and_check(m, addr, MID_BITS'(m * 5 + s), (m + s) % 4);
            end
        end
        end_test();

        // all three request in the same cycle
        begin_test("fixed priority");
        arrivals.delete();
        fork
            write_and_check(0, region_base[0] + 32'h100, 4'h1, 3);
            write_and_check(1, region_base[1] + 32'h200, 4'h2, 3);
            write_and_check(2, region_base[2] + 32'h300, 4'h3, 3);
        join
        assert (arrivals.size() == 3 && arrivals[0] == 0 && arrivals[1] == 2
                && arrivals[2] == 1)
            else report_mismatch("address arrival order is not M0, M2, M1");
        end_test();

        // long bursts from two masters at once
        begin_test("burst integrity under back-pressure");
        for (int k = 0; k < 4; k++) begin
            fork
                write_and_check(k % 3, region_base[k] + 32'(64 * k), MID_BITS'(k), 5 + k);
                write_and_check((k + 1) % 3, region_base[k + 4] + 32'h80,
                                MID_BITS'(k + 8), 15 - k);
            join
        end
        end_test();

        // M1 leaves its response pending
        begin_test("response routing");
        issue_write(1, region_base[0] + 32'h10, 4'h5, 1);
        wait_handshake(1, CH_B);
        assert (m_bvalid[0] == 1'b0 && m_bvalid[2] == 1'b0)
            else report_mismatch("response raised at a master that did not write");
        write_and_check(0, region_base[7] + 32'h20, 4'ha, 2);
        write_and_check(2, region_base[6] + 32'h30, 4'h3, 0);
        assert (m_bvalid[1] == 1'b1)
            else report_mismatch("pending M1 response was dropped");
        take_resp(1, 4'h5, RESP_OKAY);
        end_test();

        // holes in the map go to the default slave
        begin_test("unmapped address");
        write_and_check(0, 32'h0004_0000, 4'h7, 2);
        write_and_check(1, 32'h3000_1000, 4'h8, 0);
        write_and_check(2, 32'h1002_0040, 4'h9, 4);
        end_test();

        finish_run();
    end

endmodule

/* src.f */
design/bus_map_pkg.sv
design/axi_pkg.sv
design/write_addr_decoder.sv
design/write_arbiter.sv
design/write_channel_router.sv
design/write_resp_router.sv
design/write_default_slave.sv
design/write_interconnect.sv
testbench/tb_write_interconnect.sv

/* Makefile */
VERILATOR  := verilator
TOP        := tb_write_interconnect
RTL_TOP    := write_interconnect
FILELIST   := src.f
LINT_FLAGS := --lint-only -Wall --timing
SIM_FLAGS  := --binary --timing --assert -j 0
OBJ_DIR    := obj_dir
LOG        := sim.log

.PHONY: all lint sim clean

all: lint sim

# lint from the interconnect top
lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

# build and run, the log decides pass or fail
sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -qx "ALL TESTS PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
